/* Makefile */
# Verilator build and run for the TCB-Lite subsystem

VERILATOR  ?= verilator
TOP        ?= tcb_lite_subsystem_tb
RTL_TOP    ?= tcb_lite_subsystem
FILELIST   ?= tcb_lite_subsystem.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Finished with no errors
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)

# pass or fail comes from the log, not from the exit code of the run
run: build
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tcb_lite_lib_demultiplexer.sv */
`timescale 1ns/1ps
`default_nettype none

module tcb_lite_lib_demultiplexer (
    input  logic                   sub,
    input  logic                   rst,
    // manager side
    input  logic                   man_vld,
    input  tcb_lite_pkg::tcb_req_t man_req,
    output logic                   man_rdy,
    output tcb_lite_pkg::tcb_rsp_t man_rsp,
    // SRAM subordinate
    output logic                   mem_vld,
    output tcb_lite_pkg::tcb_req_t mem_req,
    input  logic                   mem_rdy,
    input  tcb_lite_pkg::tcb_rsp_t mem_rsp,
    // register bank subordinate
    output logic                   reg_vld,
    output tcb_lite_pkg::tcb_req_t reg_req,
    input  logic                   reg_rdy,
    input  tcb_lite_pkg::tcb_rsp_t reg_rsp
);

    import tcb_lite_pkg::*;

    ////////////////////
    // address decode
    ////////////////////

    // target of the current request
    sel_t sel;
    // target of the last transfer, owns the response slot
    sel_t sel_q;
    // handshake at the manager side
    logic trn;

    assign sel = man_req.adr[ADR_SEL] ? SEL_REGS : SEL_SRAM;

    ////////////////////
    // request path
    ////////////////////

    // payload fans out to both, only the target sees vld
    assign mem_req = man_req;
    assign reg_req = man_req;
    assign mem_vld = man_vld && (sel == SEL_SRAM);
    assign reg_vld = man_vld && (sel == SEL_REGS);

    // ready comes from the addressed subordinate
    assign man_rdy = (sel == SEL_SRAM) ? mem_rdy : reg_rdy;

    assign trn = man_vld && man_rdy;

    ////////////////////
    // response path
    ////////////////////

    // fixed one cycle latency, so one registered select is enough
    always_ff @(posedge sub) begin
        if (rst) begin
            sel_q <= SEL_SRAM;
        end else if (trn) begin
            sel_q <= sel;
        end
    end

    // in order by construction, at most one response per cycle
    assign man_rsp = (sel_q == SEL_SRAM) ? mem_rsp : reg_rsp;

    ////////////////////
    // checks
    ////////////////////

    // only one subordinate is addressed at a time
    assert property (@(posedge sub) disable iff (rst)
        !(mem_vld && reg_vld));

    // each subordinate answers only in the slot after its own transfer
    assert property (@(posedge sub) disable iff (rst)
        mem_rsp.vld |-> (sel_q == SEL_SRAM && $past(trn)));

    assert property (@(posedge sub) disable iff (rst)
        reg_rsp.vld |-> (sel_q == SEL_REGS && $past(trn)));

endmodule : tcb_lite_lib_demultiplexer

`default_nettype wire

/* tcb_lite_lib_register_backpressure.sv */
`timescale 1ns/1ps
`default_nettype none

module tcb_lite_lib_register_backpressure (
    input  logic                  sub,
    input  logic                  rst,
    // manager side
    input  logic                  up_vld,
    input  tcb_lite_pkg::tcb_req_t up_req,
    output logic                  up_rdy,
    output tcb_lite_pkg::tcb_rsp_t up_rsp,
    // subordinate side
    output logic                  dn_vld,
    output tcb_lite_pkg::tcb_req_t dn_req,
    input  logic                  dn_rdy,
    input  tcb_lite_pkg::tcb_rsp_t dn_rsp
);

    import tcb_lite_pkg::*;

    ////////////////////
    // skid buffer
    ////////////////////

    // request held while downstream stalls
    tcb_req_t tmp_req;

    // capture on an upstream transfer that downstream refused
    always_ff @(posedge sub) begin
        if (up_vld && up_rdy && !dn_rdy) begin
            tmp_req.wen <= up_req.wen;
            tmp_req.adr <= up_req.adr;
            tmp_req.byt <= up_req.byt;
            // only enabled lanes carry meaningful write data
            if (up_req.wen) begin
                for (int i = 0; i < BYT; i++) begin
                    if (up_req.byt[i]) begin
                        tmp_req.wdt[i*8 +: 8] <= up_req.wdt[i*8 +: 8];
                    end
                end
            end
        end
    end

    ////////////////////
    // request path
    ////////////////////

    // zero latency while open, replay of the buffer while closed
    assign dn_vld = up_rdy ? up_vld : 1'b1;
    assign dn_req = up_rdy ? up_req : tmp_req;

    // responses are not registered
    assign up_rsp = dn_rsp;

    ////////////////////
    // ready register
    ////////////////////

    // registered so up_rdy never follows up_vld combinationally
    always_ff @(posedge sub) begin
        if (rst) begin
            up_rdy <= 1'b1;
        end else if (up_rdy) begin
            // close after a stalled transfer
            up_rdy <= !(up_vld && !dn_rdy);
        end else begin
            // reopen the cycle after the replay is taken
            up_rdy <= dn_rdy;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // a stalled transfer is replayed from the buffer on the next cycle
    assert property (@(posedge sub) disable iff (rst)
        (up_vld && up_rdy && !dn_rdy) |=>
            (!up_rdy && dn_vld && dn_req.adr == $past(up_req.adr)
             && dn_req.wen == $past(up_req.wen)));

    // the replay stays valid until downstream takes it
    assert property (@(posedge sub) disable iff (rst)
        (!up_rdy && !dn_rdy) |=> (!up_rdy && dn_vld));

endmodule : tcb_lite_lib_register_backpressure

`default_nettype wire

/* tcb_lite_pkg.sv */
`default_nettype none

package tcb_lite_pkg;

    ////////////////////
    // bus widths
    ////////////////////

    // data width in bits
    localparam int unsigned DAT = 32;
    // one enable per byte lane
    localparam int unsigned BYT = DAT / 8;
    // byte address width
    localparam int unsigned ADR = 16;

    ////////////////////
    // address map
    ////////////////////

    // number of SRAM words
    localparam int unsigned SRAM_DEPTH = 256;
    // bit 15 clear is SRAM, bit 15 set is the register bank
    localparam int unsigned ADR_SEL = 15;
    // word index sits just above the byte offset, bits 9:2
    localparam int unsigned IDX_LSB = $clog2(BYT);
    localparam int unsigned IDX_W   = $clog2(SRAM_DEPTH);

    typedef logic [ADR-1:0]   adr_t;
    typedef logic [DAT-1:0]   dat_t;
    typedef logic [BYT-1:0]   byt_t;
    typedef logic [IDX_W-1:0] idx_t;

    // word offsets inside the register region
    localparam idx_t REG_SCRATCH0 = idx_t'(0);
    localparam idx_t REG_SCRATCH1 = idx_t'(1);
    localparam idx_t REG_WRCOUNT  = idx_t'(2);

    ////////////////////
    // bus payload
    ////////////////////

    // request, byte enable mode only
    typedef struct packed {
        logic wen;
        adr_t adr;
        byt_t byt;
        dat_t wdt;
    } tcb_req_t;

    // response, vld marks the one cycle the data is valid
    typedef struct packed {
        logic vld;
        dat_t rdt;
        logic err;
    } tcb_rsp_t;

    // demultiplexer target
    typedef enum logic {
        SEL_SRAM,
        SEL_REGS
    } sel_t;

    // register bank handshake FSM
    typedef enum logic {
        REGS_IDLE,
        REGS_RECOVER
    } regs_state_t;

endpackage : tcb_lite_pkg

`default_nettype wire

/* tcb_lite_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module tcb_lite_regs (
    input  logic                   sub,
    input  logic                   rst,
    input  logic                   tcb_vld,
    input  tcb_lite_pkg::tcb_req_t tcb_req,
    output logic                   tcb_rdy,
    output tcb_lite_pkg::tcb_rsp_t tcb_rsp
);

    import tcb_lite_pkg::*;

    ////////////////////
    // decode
    ////////////////////

    regs_state_t state;

    // register bank contents
    dat_t scratch0;
    dat_t scratch1;
    dat_t wrcount;

    // word offset, higher address bits ignored
    idx_t idx;
    logic trn;
    // access outside the map or to the read-only counter
    logic acc_err;
    // write that updates a register
    logic wr_ok;
    // read mux output
    dat_t rd_dat;

    assign idx     = tcb_req.adr[IDX_LSB +: IDX_W];
    assign tcb_rdy = (state == REGS_IDLE);
    assign trn     = tcb_vld && tcb_rdy;

    assign acc_err = (idx > REG_WRCOUNT) || (tcb_req.wen && idx == REG_WRCOUNT);
    assign wr_ok   = trn && tcb_req.wen && !acc_err;

    always_comb begin
        case (idx)
            REG_SCRATCH0: rd_dat = scratch0;
            REG_SCRATCH1: rd_dat = scratch1;
            REG_WRCOUNT:  rd_dat = wrcount;
            default:      rd_dat = '0;
        endcase
    end

    ////////////////////
    // handshake FSM
    ////////////////////

    // one dead cycle after every transfer
    always_ff @(posedge sub) begin
        if (rst) begin
            state <= REGS_IDLE;
        end else begin
            case (state)
                REGS_IDLE:    if (trn) state <= REGS_RECOVER;
                REGS_RECOVER: state <= REGS_IDLE;
                default:      state <= REGS_IDLE;
            endcase
        end
    end

    ////////////////////
    // register writes
    ////////////////////

    always_ff @(posedge sub) begin
        if (rst) begin
            scratch0 <= '0;
            scratch1 <= '0;
            wrcount  <= '0;
        end else if (wr_ok) begin
            // byte lanes honoured on scratch only
            for (int i = 0; i < BYT; i++) begin
                if (tcb_req.byt[i] && idx == REG_SCRATCH0) begin
                    scratch0[i*8 +: 8] <= tcb_req.wdt[i*8 +: 8];
                end
                if (tcb_req.byt[i] && idx == REG_SCRATCH1) begin
                    scratch1[i*8 +: 8] <= tcb_req.wdt[i*8 +: 8];
                end
            end
            // counts accepted writes, errors excluded
            wrcount <= wrcount + 1'b1;
        end
    end

    ////////////////////
    // response
    ////////////////////

    // rdt is zero on writes and on errors
    always_ff @(posedge sub) begin
        if (rst) begin
            tcb_rsp <= '0;
        end else begin
            tcb_rsp.vld <= trn;
            if (trn) begin
                tcb_rsp.err <= acc_err;
                tcb_rsp.rdt <= (tcb_req.wen || acc_err) ? '0 : rd_dat;
            end
        end
    end

    // after a transfer the next cycle refuses, then the bank reopens
    assert property (@(posedge sub) disable iff (rst)
        trn |=> (state == REGS_RECOVER && !trn) ##1 (state == REGS_IDLE));

endmodule : tcb_lite_regs

`default_nettype wire

/* tcb_lite_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module tcb_lite_sram (
    input  logic                   sub,
    input  logic                   tcb_vld,
    input  tcb_lite_pkg::tcb_req_t tcb_req,
    output logic                   tcb_rdy,
    output tcb_lite_pkg::tcb_rsp_t tcb_rsp,
    input  logic                   rst
);

    import tcb_lite_pkg::*;

    // storage array
    dat_t mem [SRAM_DEPTH];

    // word index from byte address
    idx_t idx;
    // handshake
    logic trn;

    // never stalls
    assign tcb_rdy = 1'b1;
    assign trn     = tcb_vld && tcb_rdy;
    assign idx     = tcb_req.adr[IDX_LSB +: IDX_W];

    ////////////////////
    // write port
    ////////////////////

    // per lane write
    always_ff @(posedge sub) begin
        if (trn && tcb_req.wen) begin
            for (int i = 0; i < BYT; i++) begin
                if (tcb_req.byt[i]) begin
                    mem[idx][i*8 +: 8] <= tcb_req.wdt[i*8 +: 8];
                end
            end
        end
    end

    ////////////////////
    // read port
    ////////////////////

    // read data lands one cycle after the transfer
    always_ff @(posedge sub) begin
        if (trn && !tcb_req.wen) begin
            tcb_rsp.rdt <= mem[idx];
        end
    end

    // response valid mirrors the transfer
    always_ff @(posedge sub) begin
        if (rst) begin
            tcb_rsp.vld <= 1'b0;
        end else begin
            tcb_rsp.vld <= trn;
        end
    end

    // memory has no error source
    assign tcb_rsp.err = 1'b0;

endmodule : tcb_lite_sram

`default_nettype wire

/* tcb_lite_subsystem.f */
tcb_lite_pkg.sv
tcb_lite_lib_register_backpressure.sv
tcb_lite_lib_demultiplexer.sv
tcb_lite_sram.sv
tcb_lite_regs.sv
tcb_lite_subsystem.sv
tcb_lite_subsystem_tb.sv

/* tcb_lite_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tcb_lite_subsystem (
    input  logic                   sub,
    input  logic                   rst,
    input  logic                   tcb_vld,
    input  tcb_lite_pkg::tcb_req_t tcb_req,
    output logic                   tcb_rdy,
    output tcb_lite_pkg::tcb_rsp_t tcb_rsp
);

    import tcb_lite_pkg::*;

    ////////////////////
    // internal links
    ////////////////////

    // slice to demultiplexer
    logic     dmx_vld;
    tcb_req_t dmx_req;
    logic     dmx_rdy;
    tcb_rsp_t dmx_rsp;

    // demultiplexer to SRAM
    logic     mem_vld;
    tcb_req_t mem_req;
    logic     mem_rdy;
    tcb_rsp_t mem_rsp;

    // demultiplexer to register bank
    logic     reg_vld;
    tcb_req_t reg_req;
    logic     reg_rdy;
    tcb_rsp_t reg_rsp;

    ////////////////////
    // instances
    ////////////////////

    // isolates the manager from the register bank stall
    tcb_lite_lib_register_backpressure register_backpressure_inst (
        .sub    (sub),
        .rst    (rst),
        .up_vld (tcb_vld),
        .up_req (tcb_req),
        .up_rdy (tcb_rdy),
        .up_rsp (tcb_rsp),
        .dn_vld (dmx_vld),
        .dn_req (dmx_req),
        .dn_rdy (dmx_rdy),
        .dn_rsp (dmx_rsp)
    );

    tcb_lite_lib_demultiplexer demultiplexer_inst (
        .sub     (sub),
        .rst     (rst),
        .man_vld (dmx_vld),
        .man_req (dmx_req),
        .man_rdy (dmx_rdy),
        .man_rsp (dmx_rsp),
        .mem_vld (mem_vld),
        .mem_req (mem_req),
        .mem_rdy (mem_rdy),
        .mem_rsp (mem_rsp),
        .reg_vld (reg_vld),
        .reg_req (reg_req),
        .reg_rdy (reg_rdy),
        .reg_rsp (reg_rsp)
    );

    tcb_lite_sram sram_inst (
        .sub     (sub),
        .tcb_vld (mem_vld),
        .tcb_req (mem_req),
        .tcb_rdy (mem_rdy),
        .tcb_rsp (mem_rsp),
        .rst     (rst)
    );

    tcb_lite_regs regs_inst (
        .sub     (sub),
        .rst     (rst),
        .tcb_vld (reg_vld),
        .tcb_req (reg_req),
        .tcb_rdy (reg_rdy),
        .tcb_rsp (reg_rsp)
    );

endmodule : tcb_lite_subsystem

`default_nettype wire

/* tcb_lite_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tcb_lite_subsystem_tb;

    import tcb_lite_pkg::*;

    ////////////////////
    // constants, types
    ////////////////////

    localparam int unsigned SEED    = 62216;
    // cycles any single wait may take
    localparam int          TIMEOUT = 200;

    // one table row, expected fields come from the model
    typedef struct packed {
        logic first;
        int   test;
        logic wen;
        adr_t adr;
        byt_t byt;
        dat_t wdt;
        dat_t exp_rdt;
        logic exp_err;
    } row_t;

    logic     sub;
    logic     rst;
    logic     tcb_vld;
    tcb_req_t tcb_req;
    logic     tcb_rdy;
    tcb_rsp_t tcb_rsp;

    // stimulus table and test bookkeeping
    row_t  rows[$];
    string test_names[$];
    int    test_errs[$];
    // rows in flight, oldest first
    int    issued[$];
    logic  next_first;

    // reference model of SRAM and register bank
    dat_t mem_model [SRAM_DEPTH];
    dat_t scratch_model [2];
    dat_t wrcount_model;

    int   err_count;
    int   rsp_count;
    int   fail_tests;
    logic aborted;

    tcb_lite_subsystem tcb_lite_subsystem_inst (
        .sub     (sub),
        .rst     (rst),
        .tcb_vld (tcb_vld),
        .tcb_req (tcb_req),
        .tcb_rdy (tcb_rdy),
        .tcb_rsp (tcb_rsp)
    );

    // 20 ns clock
    initial begin
        sub = 1'b0;
        forever #10 sub = ~sub;
    end

    ////////////////////
    // reference model
    ////////////////////

    // enabled lanes take the new byte
    function automatic dat_t merge_lanes(input dat_t old, input dat_t wdt, input byt_t byt);
        dat_t res;
        res = old;
        for (int i = 0; i < BYT; i++) begin
            if (byt[i]) begin
                res[i*8 +: 8] = wdt[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // bit 15 picks the region, bits 9:2 the word
    task automatic model_access(input logic wen, input adr_t adr, input byt_t byt,
                                input dat_t wdt, output dat_t rdt, output logic err);
        int idx;
        idx = int'(adr[9:2]);
        rdt = '0;
        err = 1'b0;
        if (!adr[15]) begin
            if (wen) begin
                mem_model[idx] = merge_lanes(mem_model[idx], wdt, byt);
            end else begin
                rdt = mem_model[idx];
            end
        end else if (idx > 2 || (wen && idx == 2)) begin
            // counter is read only, nothing above offset 2
            err = 1'b1;
        end else if (wen) begin
            scratch_model[idx] = merge_lanes(scratch_model[idx], wdt, byt);
            wrcount_model = wrcount_model + 32'd1;
        end else if (idx == 2) begin
            rdt = wrcount_model;
        end else begin
            rdt = scratch_model[idx];
        end
    endtask

    ////////////////////
    // table building
    ////////////////////

    function automatic adr_t mem_adr(input int idx);
        return adr_t'(idx << 2);
    endfunction

    function automatic adr_t reg_adr(input int off);
        return adr_t'(32'h8000 | (off << 2));
    endfunction

    task automatic start_test(input string name);
        test_names.push_back(name);
        test_errs.push_back(0);
        next_first = 1'b1;
    endtask

    task automatic add_row(input logic wen, input adr_t adr, input byt_t byt, input dat_t wdt);
        row_t row;
        row.first = next_first;
        row.test  = test_names.size() - 1;
        row.wen   = wen;
        row.adr   = adr;
        row.byt   = byt;
        row.wdt   = wdt;
        model_access(wen, adr, byt, wdt, row.exp_rdt, row.exp_err);
        rows.push_back(row);
        next_first = 1'b0;
    endtask

    task automatic build_table();
        // full words first so partial writes merge onto known data
        start_test("sram byte lanes");
        add_row(1'b1, mem_adr(3), 4'hF, $urandom());
        add_row(1'b1, mem_adr(4), 4'hF, $urandom());
        add_row(1'b1, mem_adr(255), 4'hF, $urandom());
        add_row(1'b1, mem_adr(3), 4'b0101, $urandom());
        add_row(1'b1, mem_adr(4), 4'b1000, $urandom());
        add_row(1'b1, mem_adr(255), 4'b0110, $urandom());
        add_row(1'b0, mem_adr(3), 4'hF, '0);
        add_row(1'b0, mem_adr(4), 4'hF, '0);
        add_row(1'b0, mem_adr(255), 4'hF, '0);

        start_test("scratch registers");
        add_row(1'b1, reg_adr(0), 4'hF, $urandom());
        add_row(1'b1, reg_adr(1), 4'hF, $urandom());
        add_row(1'b0, reg_adr(0), 4'hF, '0);
        add_row(1'b0, reg_adr(1), 4'hF, '0);
        add_row(1'b1, reg_adr(0), 4'b0010, $urandom());
        add_row(1'b1, reg_adr(1), 4'b1100, $urandom());
        add_row(1'b0, reg_adr(0), 4'hF, '0);
        add_row(1'b0, reg_adr(1), 4'hF, '0);
        // bits 14 and 10 lie outside the word index
        add_row(1'b0, adr_t'(16'hC400), 4'hF, '0);

        start_test("write counter");
        add_row(1'b0, reg_adr(2), 4'hF, '0);
        add_row(1'b1, reg_adr(2), 4'hF, $urandom());
        add_row(1'b0, reg_adr(2), 4'hF, '0);
        add_row(1'b1, reg_adr(1), 4'hF, $urandom());
        add_row(1'b0, reg_adr(2), 4'hF, '0);

        start_test("unmapped offsets");
        add_row(1'b0, reg_adr(3), 4'hF, '0);
        add_row(1'b1, reg_adr(3), 4'hF, $urandom());
        add_row(1'b0, reg_adr(255), 4'hF, '0);
        add_row(1'b0, reg_adr(0), 4'hF, '0);
        add_row(1'b0, reg_adr(2), 4'hF, '0);

        // back to back register pairs hit the recovery stall
        start_test("mixed burst");
        for (int i = 0; i < 6; i++) begin
            add_row(1'b1, mem_adr(20 + i), 4'hF, $urandom());
            add_row(1'b1, reg_adr(1), 4'hF, $urandom());
            add_row(1'b0, reg_adr(1), 4'hF, '0);
            add_row(1'b0, mem_adr(20 + i), 4'hF, '0);
            add_row(1'b0, reg_adr(2), 4'hF, '0);
        end
    endtask

    ////////////////////
    // driver
    ////////////////////

    // rows go out back to back, the next one on the transfer edge
    task automatic issue_rows();
        int wait_cnt;
        @(posedge sub);
        for (int r = 0; r < rows.size(); r++) begin
            tcb_vld     <= 1'b1;
            tcb_req.wen <= rows[r].wen;
            tcb_req.adr <= rows[r].adr;
            tcb_req.byt <= rows[r].byt;
            tcb_req.wdt <= rows[r].wdt;
            wait_cnt = 0;
            @(negedge sub);
            while (!tcb_rdy && wait_cnt < TIMEOUT) begin
                @(negedge sub);
                wait_cnt++;
            end
            if (!tcb_rdy) begin
                $display("timeout: tcb_rdy stayed low for %0d cycles at row %0d", TIMEOUT, r);
                err_count++;
                aborted = 1'b1;
                break;
            end
            // rdy was high through this edge, so the row is taken here
            @(posedge sub);
            issued.push_back(r);
        end
        tcb_vld <= 1'b0;
    endtask

    ////////////////////
    // checker
    ////////////////////

    task automatic report_test(input int t);
        if (test_errs[t] == 0) begin
            $display("test %0d %s: pass", t, test_names[t]);
        end else begin
            $display("test %0d %s: fail, %0d errors", t, test_names[t], test_errs[t]);
            fail_tests++;
        end
    endtask

    task automatic check_response(input int r);
        row_t row;
        int   errs;
        row  = rows[r];
        errs = 0;
        rsp_count++;
        if (tcb_rsp.err !== row.exp_err) begin
            $display("ERR tcb_rsp.err row %0d: got %h expected %h", r, tcb_rsp.err, row.exp_err);
            errs++;
        end
        // rdt carries data on reads and is zero on errors
        if ((!row.wen || row.exp_err) && tcb_rsp.rdt !== row.exp_rdt) begin
            $display("ERR tcb_rsp.rdt row %0d: got %h expected %h", r, tcb_rsp.rdt,
                     row.exp_rdt);
            errs++;
        end
        err_count += errs;
        test_errs[row.test] += errs;
        // last row closes its test
        if (r == rows.size() - 1 || rows[r + 1].first) begin
            report_test(row.test);
        end
    endtask

    // responses matched in request order
    always @(negedge sub) begin
        if (!rst && tcb_rsp.vld) begin
            if (issued.size() == 0) begin
                $display("a response arrived with no request outstanding");
                err_count++;
            end else begin
                check_response(issued.pop_front());
            end
        end
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int wait_cnt;
        void'($urandom(SEED));
        err_count     = 0;
        rsp_count     = 0;
        fail_tests    = 0;
        aborted       = 1'b0;
        next_first    = 1'b0;
        wrcount_model = '0;
        scratch_model[0] = '0;
        scratch_model[1] = '0;
        rst     = 1'b1;
        tcb_vld = 1'b0;
        tcb_req = '0;

        test_names.push_back("reset state");
        test_errs.push_back(0);
        build_table();

        repeat (8) @(posedge sub);
        rst <= 1'b0;

        // idle bus straight out of reset
        @(negedge sub);
        if (tcb_rdy !== 1'b1) begin
            $display("ERR tcb_rdy after reset: got %h expected %h", tcb_rdy, 1'b1);
            test_errs[0]++;
            err_count++;
        end
        if (tcb_rsp.vld !== 1'b0) begin
            $display("ERR tcb_rsp.vld after reset: got %h expected %h", tcb_rsp.vld, 1'b0);
            test_errs[0]++;
            err_count++;
        end
        report_test(0);

        issue_rows();

        if (!aborted) begin
            wait_cnt = 0;
            while (rsp_count < rows.size() && wait_cnt < TIMEOUT) begin
                @(negedge sub);
                wait_cnt++;
            end
        end
        // a few idle cycles so a stray extra response is caught
        repeat (4) @(negedge sub);
        if (rsp_count != rows.size()) begin
            $display("response count wrong: %0d responses for %0d requests",
                     rsp_count, rows.size());
            err_count++;
        end

        $display("tests %0d, failed %0d, responses %0d of %0d, errors %0d",
                 test_names.size(), fail_tests, rsp_count, rows.size(), err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tcb_lite_subsystem_tb

`default_nettype wire
